// File: assocDataCache.sv
`default_nettype none

// Two-way set-associative data cache, write-through
module assocDataCache #(
    parameter int blockWords = 4,
    parameter int lineCount  = 64
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               MemtoRegM,
    input  logic               MemWriteM,
    input  cacheGeomPkg::addrT a,
    input  cacheGeomPkg::wordT wd,
    output cacheGeomPkg::wordT rd,
    output logic               Stall,
    memPort.cacheSide          mem
);
    import cacheGeomPkg::*;

    localparam int tagBits = tagWidth(blockWords, lineCount);
    localparam int offBits = $clog2(blockWords);
    localparam int selBits = (offBits > 0) ? offBits : 1;

    logic                      w1Valid, w2Valid;
    logic                      w1Hit, w2Hit, hit;
    logic                      w1En, w2En;
    logic [tagBits-1:0]        w1Tag, w2Tag, addrTag;
    logic [blockWords*32-1:0]  w1Rd, w2Rd, cacheOut, blockOut;
    logic [selBits-1:0]        wordIdx;
    logic                      cwe;
    logic                      RDSel;

    // Both ways take the block returned by memory
    cacheWay #(.blockWords(blockWords), .lineCount(lineCount)) way1 (
        .clk(clk), .reset(reset), .a(a), .we(w1En), .wd(mem.MemBlock),
        .rv(w1Valid), .rtag(w1Tag), .rd(w1Rd));

    cacheWay #(.blockWords(blockWords), .lineCount(lineCount)) way2 (
        .clk(clk), .reset(reset), .a(a), .we(w2En), .wd(mem.MemBlock),
        .rv(w2Valid), .rtag(w2Tag), .rd(w2Rd));

    cacheController dcc (
        .clk(clk), .reset(reset), .hit(hit), .MemtoRegM(MemtoRegM),
        .MemWriteM(MemWriteM), .Valid(mem.Valid), .Stall(Stall),
        .RDSel(RDSel), .cwe(cwe), .op(mem.op));

    // Store path goes straight through to memory
    assign mem.a  = a;
    assign mem.wd = wd;

    // --------------------------------------------------
    // Hit logic
    // --------------------------------------------------
    assign addrTag = a[31 -: tagBits];
    assign w1Hit   = w1Valid & (w1Tag == addrTag);
    assign w2Hit   = w2Valid & (w2Tag == addrTag);
    assign hit     = w1Hit | w2Hit;

    // Way to fill
    always_comb begin
        w1En = 1'b0;
        w2En = 1'b0;
        if (cwe) begin
            if (hit) begin
                // Update the way already holding the block
                w1En = w1Hit;
                w2En = w2Hit;
            end else if (~(w1Valid ^ w2Valid)) begin
                // Both or neither valid
                w1En = 1'b1;
            end else begin
                w1En = ~w1Valid;
                w2En = ~w2Valid;
            end
        end
    end

    // --------------------------------------------------
    // Block and word selection
    // --------------------------------------------------
    assign cacheOut = w1Hit ? w1Rd : w2Rd;
    assign blockOut = RDSel ? mem.MemBlock : cacheOut;

    assign wordIdx = selBits'((a >> byteOffsetBits) & (blockWords - 1));

    // Word i lives in bits 32i up to 32i+31
    always_comb begin
        rd = blockOut[31:0];
        for (int i = 0; i < blockWords; i++) begin
            if (wordIdx == selBits'(i)) begin
                rd = blockOut[i*32 +: 32];
            end
        end
    end

    // Exactly one way written per fill
    oneWayWrite: assert property (@(posedge clk) disable iff (reset)
        !(w1En && w2En));

    // Allocation never leaves a block in both ways
    noDoubleHit: assert property (@(posedge clk) disable iff (reset)
        !(w1Hit && w2Hit));

endmodule

`default_nettype wire

// File: backingMemory.sv
`default_nettype none

// Fixed-latency main memory returning whole blocks
module backingMemory #(
    parameter int blockWords = 4,
    parameter int memWords   = 1024,
    parameter int memLatency = 3
) (
    input  logic    clk,
    input  logic    reset,
    memPort.memSide mem
);
    import cacheGeomPkg::*;
    import memBusPkg::*;

    localparam int idxBits = $clog2(memWords);
    localparam int cntBits = $clog2(memLatency + 1);

    logic [idxBits-1:0]  wordAddr;
    logic [idxBits-1:0]  blockBase;
    logic [idxBits-1:0]  wordOff;
    logic [cntBits-1:0]  count;
    logic                busy;
    wordT                words [memWords];

    // Word address and its aligned block
    assign wordAddr  = idxBits'(mem.a >> byteOffsetBits);
    assign wordOff   = wordAddr & idxBits'(blockWords - 1);
    assign blockBase = wordAddr & ~idxBits'(blockWords - 1);

    // --------------------------------------------------
    // Latency counter
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (mem.Valid) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (busy) begin
            count <= count + 1'b1;
        end else if (mem.op != memNone) begin
            // First cycle of a new request
            busy  <= 1'b1;
            count <= cntBits'(1);
        end
    end

    assign mem.Valid = busy & (count == cntBits'(memLatency));

    // Word array, store lands at the Valid edge
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < memWords; i++) begin
                words[i] <= '0;
            end
        end else if (mem.Valid && mem.op == memWrite) begin
            words[wordAddr] <= mem.wd;
        end
    end

    // Aligned block, store word merged in
    always_comb begin
        for (int i = 0; i < blockWords; i++) begin
            mem.MemBlock[i*32 +: 32] = words[blockBase | idxBits'(i)];
            if (mem.op == memWrite && wordOff == idxBits'(i)) begin
                mem.MemBlock[i*32 +: 32] = mem.wd;
            end
        end
    end

    // Request held steady until answered
    requestStable: assert property (@(posedge clk) disable iff (reset)
        (mem.op != memNone) && !mem.Valid |=> $stable(mem.op) && $stable(mem.a));

endmodule

`default_nettype wire

// File: cacheController.sv
`default_nettype none

// Miss and store sequencer
module cacheController (
    input  logic             clk,
    input  logic             reset,
    input  logic             hit,
    input  logic             MemtoRegM,
    input  logic             MemWriteM,
    input  logic             Valid,
    output logic             Stall,
    output logic             RDSel,
    output logic             cwe,
    output memBusPkg::memOpT op
);
    import memBusPkg::*;

    memOpT state;
    memOpT nextState;
    logic  needMem;
    logic  opDone;

    // Loads that miss and every store go to memory
    assign needMem = MemWriteM | (MemtoRegM & ~hit);

    // Memory finished the operation in flight
    assign opDone = (state != memNone) & Valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= memNone;
        end else begin
            state <= nextState;
        end
    end

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        nextState = state;
        case (state)
            memNone: begin
                if (MemWriteM) begin
                    nextState = memWrite;
                end else if (MemtoRegM & ~hit) begin
                    nextState = memRead;
                end
            end
            default: begin
                // Back to idle the cycle after Valid
                if (Valid) begin
                    nextState = memNone;
                end
            end
        endcase
    end

    // Stall from the request cycle until the Valid cycle
    assign Stall = (state == memNone) ? needMem : ~Valid;

    // Fill the cache and forward the block in the Valid cycle
    assign cwe   = opDone;
    assign RDSel = opDone;
    assign op    = state;

    // Memory never answers without a request
    validOnlyInFlight: assert property (@(posedge clk) disable iff (reset)
        Valid |-> state != memNone);

endmodule

`default_nettype wire

// File: cacheGeomPkg.sv
`default_nettype none

// Word, address and block geometry shared by the cache, its ways and main memory
package cacheGeomPkg;

    // One data word and one byte address
    typedef logic [31:0] wordT;
    typedef logic [31:0] addrT;

    // Byte offset within a word
    localparam int byteOffsetBits = 2;

    // Tag width left after byte offset, block offset and set index
    function automatic int tagWidth(input int blockWords, input int lineCount);
        return 30 - $clog2(blockWords) - $clog2(lineCount);
    endfunction

endpackage

`default_nettype wire

// File: cacheSubsystem.sv
`default_nettype none

// Data cache plus main memory
module cacheSubsystem #(
    parameter int blockWords = 4,
    parameter int lineCount  = 64,
    parameter int memLatency = 3,
    parameter int memWords   = 1024
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               MemtoRegM,
    input  logic               MemWriteM,
    input  cacheGeomPkg::addrT a,
    input  cacheGeomPkg::wordT wd,
    output cacheGeomPkg::wordT rd,
    output logic               Stall
);

    // Cache to memory bus
    memPort #(.blockWords(blockWords)) memBus ();

    // --------------------------------------------------
    // Cache
    // --------------------------------------------------
    assocDataCache #(
        .blockWords(blockWords),
        .lineCount (lineCount)
    ) dataCache (
        .clk(clk), .reset(reset), .MemtoRegM(MemtoRegM), .MemWriteM(MemWriteM),
        .a(a), .wd(wd), .rd(rd), .Stall(Stall), .mem(memBus.cacheSide));

    // Main memory
    backingMemory #(
        .blockWords(blockWords),
        .memWords  (memWords),
        .memLatency(memLatency)
    ) mainMem (
        .clk(clk), .reset(reset), .mem(memBus.memSide));

endmodule

`default_nettype wire

// File: cacheWay.sv
`default_nettype none

// One way of the data cache
module cacheWay #(
    parameter int blockWords = 4,
    parameter int lineCount  = 64
) (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  cacheGeomPkg::addrT                                     a,
    input  logic                                                   we,
    input  logic [blockWords*32-1:0]                               wd,
    output logic                                                   rv,
    output logic [cacheGeomPkg::tagWidth(blockWords, lineCount)-1:0] rtag,
    output logic [blockWords*32-1:0]                               rd
);
    import cacheGeomPkg::*;

    localparam int tagBits  = tagWidth(blockWords, lineCount);
    localparam int offBits  = $clog2(blockWords);
    localparam int setBits  = (lineCount > 1) ? $clog2(lineCount) : 1;

    logic [setBits-1:0]         setIdx;
    logic [lineCount-1:0]       validBits;
    logic [tagBits-1:0]         tags   [lineCount];
    logic [blockWords*32-1:0]   blocks [lineCount];

    // Set index sits just above the block offset
    assign setIdx = setBits'((a >> (byteOffsetBits + offBits)) & (lineCount - 1));

    // --------------------------------------------------
    // Valid bits, the only state cleared by reset
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            validBits <= '0;
        end else if (we) begin
            validBits[setIdx] <= 1'b1;
        end
    end

    // Tag and block storage
    always_ff @(posedge clk) begin
        if (we) begin
            tags[setIdx]   <= a[31 -: tagBits];
            blocks[setIdx] <= wd;
        end
    end

    // Asynchronous read of the indexed set
    assign rv   = validBits[setIdx];
    assign rtag = tags[setIdx];
    assign rd   = blocks[setIdx];

endmodule

`default_nettype wire

// File: filelist.f
cacheGeomPkg.sv
memBusPkg.sv
memPort.sv
cacheWay.sv
cacheController.sv
assocDataCache.sv
backingMemory.sv
cacheSubsystem.sv
tb_cacheSubsystem.sv

// File: memBusPkg.sv
`default_nettype none

// Operation types on the cache-to-memory bus
package memBusPkg;

    // Bus operation, also the controller state
    //   memNone   idle, nothing in flight
    //   memRead   block fetch for a load miss
    //   memWrite  write-through store of one word
    typedef enum logic [1:0] {
        memNone  = 2'b00,
        memRead  = 2'b01,
        memWrite = 2'b10
    } memOpT;

endpackage

`default_nettype wire

// File: memPort.sv
`default_nettype none

// Cache to main memory bus
interface memPort #(
    parameter int blockWords = 4
);
    import cacheGeomPkg::*;
    import memBusPkg::*;

    // Request side, held steady until Valid
    memOpT op;
    addrT  a;
    wordT  wd;

    // Completion pulse and returned block
    logic                      Valid;
    logic [blockWords*32-1:0]  MemBlock;

    // Cache drives the request and takes the block
    modport cacheSide (
        output op, a, wd,
        input  Valid, MemBlock
    );

    // Memory answers the request
    modport memSide (
        input  op, a, wd,
        output Valid, MemBlock
    );

endinterface

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps -f filelist.f \
    --top-module tb_cacheSubsystem -o simCache &&
out="$(./obj_dir/simCache)" &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED" || exit 1

// File: tb_cacheSubsystem.sv
`default_nettype none

// Testbench for the two-way data cache with its main memory
module tb_cacheSubsystem;
    timeunit 1ns;
    timeprecision 100ps;

    import cacheGeomPkg::*;

    // DUT geometry and timing
    localparam int blockWords = 4;
    localparam int lineCount  = 64;
    localparam int memLatency = 3;
    localparam int memWords   = 1024;
    localparam int idxBits    = $clog2(memWords);

    // Clock and run length
    localparam int clkPeriod      = 40;
    localparam int resetCycles    = 16;
    localparam int directedCount  = 21;
    localparam int randomCount    = 300;
    localparam int requestCount   = memWords + directedCount + randomCount;
    localparam int watchdogCycles = requestCount * (memLatency + 3) + 3 * resetCycles + 200;

    // Expected stall lengths (negative accepts hit or miss)
    localparam int missStall = memLatency + 1;
    localparam int anyStall  = -1;

    logic clk;
    logic reset;
    logic MemtoRegM;
    logic MemWriteM;
    addrT a;
    wordT wd;
    wordT rd;
    logic Stall;

    // Shadow of main memory
    wordT shadow [memWords];

    int   dataErrors;
    int   timingErrors;
    int   loadsIssued;
    int   loadsChecked;
    logic [31:0] rngState;

    cacheSubsystem #(
        .blockWords(blockWords),
        .lineCount (lineCount),
        .memLatency(memLatency),
        .memWords  (memWords)
    ) u_dut (
        .clk(clk), .reset(reset), .MemtoRegM(MemtoRegM), .MemWriteM(MemWriteM),
        .a(a), .wd(wd), .rd(rd), .Stall(Stall));

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic logic [idxBits-1:0] wordIndex(input addrT addr);
        return idxBits'(addr >> byteOffsetBits);
    endfunction

    // Expected load data comes from the shadow
    function automatic wordT expectedLoad(input addrT addr);
        return shadow[wordIndex(addr)];
    endfunction

    // xorshift32 step
    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Free-running clock
    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Reset clears main memory and its shadow
    task automatic applyReset();
        @(posedge clk);
        #2;
        reset     = 1'b1;
        MemtoRegM = 1'b0;
        MemWriteM = 1'b0;
        for (int i = 0; i < memWords; i++) begin
            shadow[i] = '0;
        end
        repeat (resetCycles) @(posedge clk);
        #2;
        reset = 1'b0;
    endtask

    // Hold one request until Stall drops and check the stall length
    task automatic runRequest(input logic isStore, input addrT addr, input wordT data,
                              input int expStall);
        int stallCycles;
        @(posedge clk);
        #2;
        MemtoRegM = ~isStore;
        MemWriteM = isStore;
        a         = addr;
        wd        = data;
        stallCycles = 0;
        // Sample Stall mid-cycle
        @(negedge clk);
        while (Stall) begin
            stallCycles++;
            @(negedge clk);
        end
        if (expStall >= 0 && stallCycles != expStall) begin
            $display("CHECK FAILED t=%0t Stall cycles at a=%08h expected %0d got %0d",
                     $time, addr, expStall, stallCycles);
            timingErrors++;
        end
        if (expStall < 0 && stallCycles != 0 && stallCycles != missStall) begin
            $display("CHECK FAILED t=%0t Stall cycles at a=%08h expected 0 or %0d got %0d",
                     $time, addr, missStall, stallCycles);
            timingErrors++;
        end
        if (!isStore) begin
            loadsIssued++;
        end
        // Drop the request after the completing edge
        @(posedge clk);
        #2;
        MemtoRegM = 1'b0;
        MemWriteM = 1'b0;
    endtask

    // --------------------------------------------------
    // Checker for the completing cycle of each request
    // --------------------------------------------------
    always @(negedge clk) begin
        wordT expected;
        if (!reset && !Stall) begin
            if (MemtoRegM) begin
                expected = expectedLoad(a);
                if (rd !== expected) begin
                    $display("CHECK FAILED t=%0t rd at a=%08h expected %08h got %08h",
                             $time, a, expected, rd);
                    dataErrors++;
                end
                loadsChecked++;
            end else if (MemWriteM) begin
                // Store lands in memory at the next edge
                shadow[wordIndex(a)] = wd;
            end
        end
    end

    // Watchdog
    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Timeout: run did not finish within %0d cycles", watchdogCycles);
        $display("CHECKS FAILED");
        $finish;
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        logic isStore;
        addrT addr;
        wordT data;
        reset        = 1'b1;
        MemtoRegM    = 1'b0;
        MemWriteM    = 1'b0;
        a            = '0;
        wd           = '0;
        dataErrors   = 0;
        timingErrors = 0;
        loadsIssued  = 0;
        loadsChecked = 0;
        rngState     = 32'hd8d0750b;

        // Sweep every word where the first word of each block misses
        applyReset();
        for (int i = 0; i < memWords; i++) begin
            runRequest(1'b0, addrT'(i * 4), '0, (i % blockWords == 0) ? missStall : 0);
        end

        // Store to an uncached block and read it back
        applyReset();
        runRequest(1'b1, 32'h0000_0100, 32'ha5a5_0001, missStall);
        runRequest(1'b0, 32'h0000_0100, '0, 0);
        runRequest(1'b0, 32'h0000_0104, '0, 0);
        // Store to a cached block
        runRequest(1'b0, 32'h0000_0208, '0, missStall);
        runRequest(1'b1, 32'h0000_0208, 32'h5a5a_0002, missStall);
        runRequest(1'b0, 32'h0000_0208, '0, 0);

        // Two tags in set 3 fill both ways
        runRequest(1'b0, 32'h0000_0030, '0, missStall);
        runRequest(1'b0, 32'h0000_0434, '0, missStall);
        runRequest(1'b0, 32'h0000_0038, '0, 0);
        runRequest(1'b0, 32'h0000_043c, '0, 0);

        // Distinct words in one block of set 24
        for (int k = 0; k < blockWords; k++) begin
            runRequest(1'b1, addrT'(32'h0000_0180 + k * 4), 32'hc0de_0000 + k, missStall);
        end
        // Two other tags evict it
        runRequest(1'b0, 32'h0000_0580, '0, missStall);
        runRequest(1'b0, 32'h0000_0980, '0, missStall);
        // Refetch, then every word offset hits
        runRequest(1'b0, 32'h0000_0188, '0, missStall);
        for (int k = 0; k < blockWords; k++) begin
            runRequest(1'b0, addrT'(32'h0000_0180 + k * 4), '0, 0);
        end

        // Random mix of four tags over two sets forces evictions
        for (int n = 0; n < randomCount; n++) begin
            rngState = nextRandom(rngState);
            addr     = rngState & 32'h0000_0c1c;
            isStore  = rngState[0];
            rngState = nextRandom(rngState);
            data     = rngState;
            runRequest(isStore, addr, data, isStore ? missStall : anyStall);
        end

        if (loadsChecked != loadsIssued) begin
            $display("Checker saw %0d completed loads but %0d were issued",
                     loadsChecked, loadsIssued);
            dataErrors++;
        end

        $display("Data errors: %0d, timing errors: %0d, loads checked: %0d",
                 dataErrors, timingErrors, loadsChecked);
        if (dataErrors == 0 && timingErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
